// ==== pcie_pkg.sv ====
`default_nettype none

package pcie_pkg;

    // bus widths
    localparam int DATA_WIDTH      = 64;
    localparam int HOST_ADDR_WIDTH = 64;
    localparam int MMIO_ADDR_WIDTH = 16;

    // ring geometry
    localparam int NB_QUEUES_DEFAULT = 4;
    localparam int QIDX_WIDTH        = 3;
    localparam int RING_IDX_WIDTH    = 16;
    localparam int SLOT_BYTES        = 8;

    // register select, address bits 4:3
    typedef enum logic [1:0] {
        REG_BASE = 2'd0,
        REG_HEAD = 2'd1,
        REG_TAIL = 2'd2
    } reg_sel_e;

    // global page reuses the same select field
    localparam reg_sel_e REG_CONTROL = REG_BASE;
    localparam reg_sel_e REG_DROPS   = REG_HEAD;

    // control word, disable_dma is bit 0
    typedef struct packed {
        logic [56:0] reserved;
        logic [4:0]  ring_log2;
        logic        sw_reset;
        logic        disable_dma;
    } ctrl_t;

    typedef struct packed {
        logic [HOST_ADDR_WIDTH-1:0] base;
        logic [RING_IDX_WIDTH-1:0]  head;
        logic [RING_IDX_WIDTH-1:0]  tail;
        logic                       full;
        logic [HOST_ADDR_WIDTH-1:0] slot_addr;
    } ring_state_t;

    typedef struct packed {
        logic [QIDX_WIDTH-1:0] queue;
        logic [DATA_WIDTH-1:0] data;
    } pkt_word_t;

    typedef struct packed {
        logic                  base_we;
        logic                  head_we;
        logic [DATA_WIDTH-1:0] wdata;
    } ring_cmd_t;

    typedef enum logic {
        DMA_IDLE,
        DMA_WRITE
    } dma_state_e;

endpackage

`default_nettype wire

// ==== pcie_mmio_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module pcie_mmio_regs #(
    parameter int nb_queues = pcie_pkg::NB_QUEUES_DEFAULT
) (
    input  logic                                 pcie_clk,
    input  logic                                 rst_n,
    input  logic [pcie_pkg::MMIO_ADDR_WIDTH-1:0] mmio_address,
    input  logic                                 mmio_write,
    input  logic                                 mmio_read,
    input  logic [pcie_pkg::DATA_WIDTH-1:0]      mmio_writedata,
    output logic [pcie_pkg::DATA_WIDTH-1:0]      mmio_readdata,
    output logic                                 mmio_readdatavalid,
    input  var pcie_pkg::ring_state_t            ring_state [nb_queues],
    input  logic [pcie_pkg::DATA_WIDTH-1:0]      drop_count,
    output pcie_pkg::ctrl_t                      ctrl,
    output pcie_pkg::ring_cmd_t                  ring_cmd [nb_queues]
);

import pcie_pkg::*;

logic [QIDX_WIDTH-1:0] qidx;
reg_sel_e              sel;
logic                  is_global;
logic [DATA_WIDTH-1:0] rd_mux;

// queue page in bits 12 and up, register in bits 4:3
assign qidx = mmio_address[12 +: QIDX_WIDTH];
assign sel  = reg_sel_e'(mmio_address[4:3]);

// first index past the rings is the global page
assign is_global = (qidx == QIDX_WIDTH'(nb_queues));

// write strobes go straight to the addressed ring
always_comb begin
    for (int q = 0; q < nb_queues; q++) begin
        ring_cmd[q].base_we = mmio_write && (qidx == QIDX_WIDTH'(q)) && (sel == REG_BASE);
        ring_cmd[q].head_we = mmio_write && (qidx == QIDX_WIDTH'(q)) && (sel == REG_HEAD);
        ring_cmd[q].wdata   = mmio_writedata;
    end
end

always_ff @(posedge pcie_clk) begin
    if (!rst_n) begin
        ctrl <= '0;
    end else if (mmio_write && is_global && (sel == REG_CONTROL)) begin
        ctrl <= ctrl_t'(mmio_writedata);
    end
end

// readback mux, zero for anything unmapped
always_comb begin
    rd_mux = '0;
    for (int q = 0; q < nb_queues; q++) begin
        if (qidx == QIDX_WIDTH'(q)) begin
            case (sel)
                REG_BASE: rd_mux = DATA_WIDTH'(ring_state[q].base);
                REG_HEAD: rd_mux = DATA_WIDTH'(ring_state[q].head);
                REG_TAIL: rd_mux = DATA_WIDTH'(ring_state[q].tail);
                default:  rd_mux = '0;
            endcase
        end
    end
    if (is_global) begin
        case (sel)
            REG_CONTROL: rd_mux = DATA_WIDTH'(ctrl);
            REG_DROPS:   rd_mux = drop_count;
            default:     rd_mux = '0;
        endcase
    end
end

// one cycle read latency
always_ff @(posedge pcie_clk) begin
    if (!rst_n) begin
        mmio_readdatavalid <= 1'b0;
    end else begin
        mmio_readdatavalid <= mmio_read;
    end
end

always_ff @(posedge pcie_clk) begin
    if (mmio_read) begin
        mmio_readdata <= rd_mux;
    end
end

endmodule

`default_nettype wire

// ==== queue_ring.sv ====
`timescale 1ns/1ns
`default_nettype none

module queue_ring (
    input  logic                    pcie_clk,
    input  logic                    rst_n,
    input  var pcie_pkg::ctrl_t     ctrl,
    input  var pcie_pkg::ring_cmd_t cmd,
    input  logic                    tail_advance,
    output pcie_pkg::ring_state_t   state
);

import pcie_pkg::*;

logic [HOST_ADDR_WIDTH-1:0] base;
logic [RING_IDX_WIDTH-1:0]  head;
logic [RING_IDX_WIDTH-1:0]  tail;
logic [RING_IDX_WIDTH-1:0]  tail_next;
logic [RING_IDX_WIDTH-1:0]  idx_mask;
logic [RING_IDX_WIDTH:0]    entries;

// entries is 2^ring_log2 with one extra bit so 2^16 fits
assign entries  = {{RING_IDX_WIDTH{1'b0}}, 1'b1} << ctrl.ring_log2;
assign idx_mask = RING_IDX_WIDTH'(entries - (RING_IDX_WIDTH+1)'(1));

// wrap by masking to the ring size
assign tail_next = (tail + RING_IDX_WIDTH'(1)) & idx_mask;

always_ff @(posedge pcie_clk) begin
    if (!rst_n) begin
        base <= '0;
        head <= '0;
        tail <= '0;
    end else begin
        if (cmd.base_we) begin
            base <= HOST_ADDR_WIDTH'(cmd.wdata);
        end
        // software moves the consumer head
        if (cmd.head_we) begin
            head <= cmd.wdata[RING_IDX_WIDTH-1:0] & idx_mask;
        end
        if (tail_advance) begin
            tail <= tail_next;
        end
    end
end

// one slot is kept empty to tell full from empty
always_comb begin
    state.base      = base;
    state.head      = head;
    state.tail      = tail;
    state.full      = (tail_next == head);
    state.slot_addr = base + (HOST_ADDR_WIDTH'(tail) * HOST_ADDR_WIDTH'(SLOT_BYTES));
end

endmodule

`default_nettype wire

// ==== f2c_dma_writer.sv ====
`timescale 1ns/1ns
`default_nettype none

module f2c_dma_writer #(
    parameter int nb_queues = pcie_pkg::NB_QUEUES_DEFAULT
) (
    input  logic                                 pcie_clk,
    input  logic                                 rst_n,
    input  var pcie_pkg::ctrl_t                  ctrl,
    input  var pcie_pkg::ring_state_t            ring_state [nb_queues],
    input  var pcie_pkg::pkt_word_t              pkt_in,
    input  logic                                 pkt_wr_en,
    output logic                                 pkt_in_ready,
    output logic [nb_queues-1:0]                 tail_advance,
    output logic [pcie_pkg::DATA_WIDTH-1:0]      drop_count,
    input  logic                                 bas_waitrequest,
    output logic [pcie_pkg::HOST_ADDR_WIDTH-1:0] bas_address,
    output logic                                 bas_write,
    output logic [pcie_pkg::DATA_WIDTH-1:0]      bas_writedata,
    output logic [3:0]                           bas_burstcount
);

import pcie_pkg::*;

dma_state_e                 state;
logic [QIDX_WIDTH-1:0]      cur_q;
logic                       accept;
logic                       drop;
logic                       write_done;
logic                       q_valid;
logic                       q_full;
logic [HOST_ADDR_WIDTH-1:0] q_slot_addr;

// ring lookup for the incoming word
always_comb begin
    q_valid     = 1'b0;
    q_full      = 1'b0;
    q_slot_addr = '0;
    for (int q = 0; q < nb_queues; q++) begin
        if (pkt_in.queue == QIDX_WIDTH'(q)) begin
            q_valid     = 1'b1;
            q_full      = ring_state[q].full;
            q_slot_addr = ring_state[q].slot_addr;
        end
    end
end

assign pkt_in_ready = (state == DMA_IDLE) && !ctrl.disable_dma;
assign accept       = pkt_wr_en && pkt_in_ready;

// words for a full ring or a nonexistent queue are discarded
assign drop = accept && (!q_valid || q_full);

// single beat writes only
assign bas_write      = (state == DMA_WRITE);
assign bas_burstcount = 4'd1;
assign write_done     = bas_write && !bas_waitrequest;

// tail moves on the edge that completes the write
always_comb begin
    for (int q = 0; q < nb_queues; q++) begin
        tail_advance[q] = write_done && (cur_q == QIDX_WIDTH'(q));
    end
end

always_ff @(posedge pcie_clk) begin
    if (!rst_n) begin
        state <= DMA_IDLE;
    end else begin
        case (state)
            DMA_IDLE: begin
                if (accept && !drop) begin
                    state <= DMA_WRITE;
                end
            end
            DMA_WRITE: begin
                // hold address and data until the host takes them
                if (!bas_waitrequest) begin
                    state <= DMA_IDLE;
                end
            end
        endcase
    end
end

// capture the word and where it goes
always_ff @(posedge pcie_clk) begin
    if (accept && !drop) begin
        bas_address   <= q_slot_addr;
        bas_writedata <= pkt_in.data;
        cur_q         <= pkt_in.queue;
    end
end

// drop counter held at zero while sw_reset is set
always_ff @(posedge pcie_clk) begin
    if (!rst_n || ctrl.sw_reset) begin
        drop_count <= '0;
    end else if (drop) begin
        drop_count <= drop_count + DATA_WIDTH'(1);
    end
end

endmodule

`default_nettype wire

// ==== pcie_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module pcie_top #(
    parameter int nb_queues = pcie_pkg::NB_QUEUES_DEFAULT
) (
    input  logic                                 pcie_clk,
    input  logic                                 rst_n,

    // mmio slave
    input  logic [pcie_pkg::MMIO_ADDR_WIDTH-1:0] mmio_address,
    input  logic                                 mmio_write,
    input  logic                                 mmio_read,
    input  logic [pcie_pkg::DATA_WIDTH-1:0]      mmio_writedata,
    output logic [pcie_pkg::DATA_WIDTH-1:0]      mmio_readdata,
    output logic                                 mmio_readdatavalid,

    // packet words from the capture side
    input  var pcie_pkg::pkt_word_t              pkt_in,
    input  logic                                 pkt_wr_en,
    output logic                                 pkt_in_ready,

    // burst master towards host memory
    input  logic                                 bas_waitrequest,
    output logic [pcie_pkg::HOST_ADDR_WIDTH-1:0] bas_address,
    output logic                                 bas_write,
    output logic [pcie_pkg::DATA_WIDTH-1:0]      bas_writedata,
    output logic [3:0]                           bas_burstcount,

    output logic                                 disable_pcie
);

import pcie_pkg::*;

ctrl_t                 ctrl;
ring_cmd_t             ring_cmd   [nb_queues];
ring_state_t           ring_state [nb_queues];
logic [nb_queues-1:0]  tail_advance;
logic [DATA_WIDTH-1:0] drop_count;

assign disable_pcie = ctrl.disable_dma;

pcie_mmio_regs #(
    .nb_queues (nb_queues)
) u_regs (
    .pcie_clk           (pcie_clk),
    .rst_n              (rst_n),
    .mmio_address       (mmio_address),
    .mmio_write         (mmio_write),
    .mmio_read          (mmio_read),
    .mmio_writedata     (mmio_writedata),
    .mmio_readdata      (mmio_readdata),
    .mmio_readdatavalid (mmio_readdatavalid),
    .ring_state         (ring_state),
    .drop_count         (drop_count),
    .ctrl               (ctrl),
    .ring_cmd           (ring_cmd)
);

// one ring per queue
for (genvar q = 0; q < nb_queues; q++) begin : g_ring
    queue_ring u_ring (
        .pcie_clk     (pcie_clk),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .cmd          (ring_cmd[q]),
        .tail_advance (tail_advance[q]),
        .state        (ring_state[q])
    );
end

f2c_dma_writer #(
    .nb_queues (nb_queues)
) u_writer (
    .pcie_clk        (pcie_clk),
    .rst_n           (rst_n),
    .ctrl            (ctrl),
    .ring_state      (ring_state),
    .pkt_in          (pkt_in),
    .pkt_wr_en       (pkt_wr_en),
    .pkt_in_ready    (pkt_in_ready),
    .tail_advance    (tail_advance),
    .drop_count      (drop_count),
    .bas_waitrequest (bas_waitrequest),
    .bas_address     (bas_address),
    .bas_write       (bas_write),
    .bas_writedata   (bas_writedata),
    .bas_burstcount  (bas_burstcount)
);

endmodule

`default_nettype wire

// ==== pcie_top_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pcie_top_tb;

import pcie_pkg::*;

localparam int TOKW = 8 * 24;
typedef logic [TOKW-1:0] token_t;

logic                       pcie_clk;
logic                       rst_n;
logic [MMIO_ADDR_WIDTH-1:0] mmio_address;
logic                       mmio_write;
logic                       mmio_read;
logic [DATA_WIDTH-1:0]      mmio_writedata;
logic [DATA_WIDTH-1:0]      mmio_readdata;
logic                       mmio_readdatavalid;
pkt_word_t                  pkt_in;
logic                       pkt_wr_en;
logic                       pkt_in_ready;
logic                       bas_waitrequest = 1'b0;
logic [HOST_ADDR_WIDTH-1:0] bas_address;
logic                       bas_write;
logic [DATA_WIDTH-1:0]      bas_writedata;
logic [3:0]                 bas_burstcount;
logic                       disable_pcie;

integer seed = 32'h7b1c;
logic   wr_random;
token_t test_name;
int     errors;
int     hold_errors = 0;
int     cycles = 0;
int     cycle_limit;

// completed bus writes as seen by the host model
logic [HOST_ADDR_WIDTH-1:0] cap_addr [0:255];
logic [DATA_WIDTH-1:0]      cap_data [0:255];
int                         cap_count = 0;
int                         cap_seen;
logic                       held_valid = 1'b0;
logic [HOST_ADDR_WIDTH-1:0] held_addr;
logic [DATA_WIDTH-1:0]      held_data;

pcie_top #(
    .nb_queues (4)
) u_dut (
    .pcie_clk           (pcie_clk),
    .rst_n              (rst_n),
    .mmio_address       (mmio_address),
    .mmio_write         (mmio_write),
    .mmio_read          (mmio_read),
    .mmio_writedata     (mmio_writedata),
    .mmio_readdata      (mmio_readdata),
    .mmio_readdatavalid (mmio_readdatavalid),
    .pkt_in             (pkt_in),
    .pkt_wr_en          (pkt_wr_en),
    .pkt_in_ready       (pkt_in_ready),
    .bas_waitrequest    (bas_waitrequest),
    .bas_address        (bas_address),
    .bas_write          (bas_write),
    .bas_writedata      (bas_writedata),
    .bas_burstcount     (bas_burstcount),
    .disable_pcie       (disable_pcie)
);

initial pcie_clk = 1'b0;
always #4 pcie_clk = ~pcie_clk;

// hard stop sized from the number of cases
always @(posedge pcie_clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
        $display("timeout: run went past %0d cycles", cycle_limit);
        $display("Test FAILED");
        $finish;
    end
end

// host memory model drives waitrequest for the coming edge and captures writes
always @(negedge pcie_clk) begin : host_model
    logic [31:0] rnd;
    logic        stall;
    rnd = 32'd0;
    if (wr_random) begin
        rnd = $random(seed);
    end
    stall = rnd[0];
    // a stalled write has to stay put
    if (held_valid) begin
        assert (bas_write && bas_address == held_addr && bas_writedata == held_data) else begin
            $display("bus write dropped or changed while waitrequest was high");
            hold_errors++;
        end
    end
    bas_waitrequest = stall;
    if (bas_write && !stall) begin
        assert (bas_burstcount == 4'd1) else begin
            $display("[FAIL] %0s burstcount: expected %0d, actual %0d",
                     test_name, 4'd1, bas_burstcount);
            hold_errors++;
        end
        cap_addr[cap_count[7:0]] = bas_address;
        cap_data[cap_count[7:0]] = bas_writedata;
        cap_count++;
    end
    held_valid = bas_write && stall;
    held_addr  = bas_address;
    held_data  = bas_writedata;
end

task automatic mmio_wr(input logic [63:0] addr, input logic [63:0] data);
    mmio_address   = addr[MMIO_ADDR_WIDTH-1:0];
    mmio_writedata = data;
    mmio_write     = 1'b1;
    @(negedge pcie_clk);
    mmio_write     = 1'b0;
endtask

task automatic mmio_rd_check(input logic [63:0] addr, input logic [63:0] exp);
    mmio_address = addr[MMIO_ADDR_WIDTH-1:0];
    mmio_read    = 1'b1;
    @(negedge pcie_clk);
    mmio_read    = 1'b0;
    // data valid exactly one cycle after the strobe
    assert (mmio_readdatavalid) else begin
        $display("%0s: readdatavalid missing one cycle after the read strobe", test_name);
        errors++;
    end
    if (mmio_readdatavalid) begin
        assert (mmio_readdata == exp) else begin
            $display("[FAIL] %0s: expected %h, actual %h", test_name, exp, mmio_readdata);
            errors++;
        end
    end
    @(negedge pcie_clk);
    assert (!mmio_readdatavalid) else begin
        $display("%0s: readdatavalid stayed high for a second cycle", test_name);
        errors++;
    end
endtask

task automatic send_pkt(input logic [2:0] q, input logic [63:0] data,
                        input token_t mode, input logic [63:0] exp_addr);
    int waited;
    waited = 0;
    if (mode == token_t'("HOLD")) begin
        pkt_in.queue = q;
        pkt_in.data  = data;
        pkt_wr_en    = 1'b1;
        repeat (8) begin
            @(negedge pcie_clk);
            assert (!pkt_in_ready && disable_pcie && !bas_write) else begin
                $display("%0s: word taken or disable_pcie low while disabled", test_name);
                errors++;
            end
        end
        pkt_wr_en = 1'b0;
    end else begin
        while (!pkt_in_ready) @(negedge pcie_clk);
        pkt_in.queue = q;
        pkt_in.data  = data;
        pkt_wr_en    = 1'b1;
        @(negedge pcie_clk);
        pkt_wr_en    = 1'b0;
        if (mode == token_t'("DROP")) begin
            repeat (3) begin
                assert (!bas_write) else begin
                    $display("%0s: bus write for a word that should be dropped", test_name);
                    errors++;
                end
                @(negedge pcie_clk);
            end
        end else begin
            // capture count is only read on rising edges
            do begin
                @(posedge pcie_clk);
                waited++;
            end while (cap_count == cap_seen && waited < 48);
            assert (cap_count != cap_seen) else begin
                $display("%0s: no bus write seen for the packet word", test_name);
                errors++;
            end
            if (cap_count != cap_seen) begin
                assert (cap_addr[cap_seen[7:0]] == exp_addr) else begin
                    $display("[FAIL] %0s address: expected %h, actual %h",
                             test_name, exp_addr, cap_addr[cap_seen[7:0]]);
                    errors++;
                end
                assert (cap_data[cap_seen[7:0]] == data) else begin
                    $display("[FAIL] %0s data: expected %h, actual %h",
                             test_name, data, cap_data[cap_seen[7:0]]);
                    errors++;
                end
                cap_seen++;
            end
            @(negedge pcie_clk);
        end
    end
endtask

initial begin : main
    integer           fd;
    integer           rc;
    int               ncases;
    int               ntests;
    int               failed_tests;
    int               errs_before;
    token_t           tok;
    token_t           op;
    token_t           mode;
    logic [63:0]      a;
    logic [63:0]      b;
    logic [63:0]      c;
    logic [8*128-1:0] rest;

    rst_n          = 1'b0;
    mmio_address   = '0;
    mmio_write     = 1'b0;
    mmio_read      = 1'b0;
    mmio_writedata = '0;
    pkt_in         = '0;
    pkt_wr_en      = 1'b0;
    wr_random      = 1'b0;
    errors         = 0;
    cap_seen       = 0;
    cycle_limit    = 0;
    ncases         = 0;
    ntests         = 0;
    failed_tests   = 0;
    c              = '0;
    test_name      = token_t'("reset");

    fd = $fopen("pcie_cases.txt", "r");
    if (fd == 0) begin
        $display("cannot open pcie_cases.txt");
        $display("Test FAILED");
        $finish;
    end else begin
        // first pass counts the cases for the timeout
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok != token_t'("#")) begin
                ncases++;
            end
            rc = $fgets(rest, fd);
        end
        $fclose(fd);
        cycle_limit = ncases * 64;
        fd = $fopen("pcie_cases.txt", "r");

        repeat (16) @(negedge pcie_clk);
        rst_n = 1'b1;
        assert (pkt_in_ready && !bas_write && !mmio_readdatavalid && !disable_pcie) else begin
            $display("outputs not at their reset values after reset");
            errors++;
        end

        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == token_t'("#")) begin
                rc = $fgets(rest, fd);
            end else begin
                test_name   = tok;
                errs_before = errors + hold_errors;
                rc = $fscanf(fd, "%s", op);
                case (op)
                    token_t'("W"): begin
                        rc = $fscanf(fd, "%h %h", a, b);
                        mmio_wr(a, b);
                    end
                    token_t'("R"): begin
                        rc = $fscanf(fd, "%h %h", a, b);
                        mmio_rd_check(a, b);
                    end
                    token_t'("P"): begin
                        rc = $fscanf(fd, "%h %h %s", a, b, mode);
                        if (mode != token_t'("DROP") && mode != token_t'("HOLD")) begin
                            rc = $sscanf(mode, "%h", c);
                        end
                        send_pkt(a[2:0], b, mode, c);
                    end
                    token_t'("D"): begin
                        rc = $fscanf(fd, "%s", mode);
                        wr_random = (mode == token_t'("random"));
                    end
                    default: begin
                        $display("%0s: unknown opcode in the cases file", test_name);
                        errors++;
                    end
                endcase
                ntests++;
                if (errors + hold_errors == errs_before) begin
                    $display("test %0s: passed", test_name);
                end else begin
                    failed_tests++;
                    $display("test %0s: failed", test_name);
                end
            end
        end
        $fclose(fd);

        @(posedge pcie_clk);
        assert (cap_count == cap_seen) else begin
            $display("%0d bus writes seen that no packet asked for", cap_count - cap_seen);
            errors++;
        end
        errors = errors + hold_errors;
        $display("tests: %0d run, %0d failed, %0d check errors", ntests, failed_tests, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end
end

endmodule

`default_nettype wire

// ==== pcie_cases.txt ====
# columns: name opcode operands, all numbers hex
# W addr data | R addr expected | P queue data host_addr or DROP or HOLD | D off or random
ctl_init    W 4000 10
base0       W 0000 10000000
base0_rd    R 0000 10000000
head1       W 1008 5
head1_rd    R 1008 5
ctl_rd      R 4000 10
unmap_sel3  R 0018 0
unmap_q5    R 5000 0
unmap_glob  R 4010 0
tail_ro     W 0010 7
tail0_rd    R 0010 0
place_a     P 0 1111aaaa00000001 10000000
place_b     P 0 1111aaaa00000002 10000008
place_tail  R 0010 2
ctl_log2    W 4000 8
base2       W 2000 30000000
wrap_p1     P 2 2222cccc00000001 30000000
wrap_p2     P 2 2222cccc00000002 30000008
wrap_p3     P 2 2222cccc00000003 30000010
wrap_head   W 2008 3
wrap_p4     P 2 2222cccc00000004 30000018
wrap_p5     P 2 2222cccc00000005 30000000
wrap_tail   R 2010 1
base3       W 3000 40000000
full_p1     P 3 3333dddd00000001 40000000
full_p2     P 3 3333dddd00000002 40000008
full_p3     P 3 3333dddd00000003 40000010
full_p4     P 3 3333dddd00000004 DROP
full_drops  R 4008 1
full_head   W 3008 1
full_p5     P 3 3333dddd00000005 40000018
full_tail   R 3010 0
dis_on      W 4000 9
dis_hold    P 0 deadbeef00000000 HOLD
swr_on      W 4000 a
swr_off     W 4000 8
swr_drops   R 4008 0
bp_mode     D random
bp_head0    W 0008 2
bp_p1       P 0 5555eeee00000001 10000010
bp_p2       P 0 5555eeee00000002 10000018
bp_p3       P 0 5555eeee00000003 10000000
bp_drop     P 3 5555eeee00000004 DROP
bp_tail0    R 0010 1
bp_drops    R 4008 1

// ==== pcie_top.f ====
pcie_pkg.sv
pcie_mmio_regs.sv
queue_ring.sv
f2c_dma_writer.sv
pcie_top.sv
pcie_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it and judge the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module pcie_top_tb \
    -f pcie_top.f -o pcie_top_sim \
    && ./obj_dir/pcie_top_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation reported failure"; exit 1; } || exit 0
